// ==== Makefile ====
# Verilator build and run of the serial execution slice testbench

VERILATOR ?= verilator
TOP       ?= tb_serial_exec
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --timescale 1ns/10ps

.PHONY: sim clean

# A failing run stops with a non-zero exit status
sim:
	$(VERILATOR) $(VFLAGS) --build-jobs $(JOBS) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
+incdir+hw
hw/serial_core_pkg.sv
hw/serial_state.sv
hw/serial_decode.sv
hw/serial_alu.sv
hw/serial_exec_top.sv
sim/tb_clock_gen.sv
sim/tb_serial_exec.sv

// ==== hw/serial_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "serial_core_defines.svh"

module serial_alu
   import serial_core_pkg::*;
(
   input  wire                       clk,
   input  wire                       i_rst_n,
   input  wire                       i_load,
   input  wire  [`SC_XLEN-1:0]       i_rs1,
   input  wire  [`SC_XLEN-1:0]       i_rs2,
   input  wire  dec_ctrl_t           i_ctrl,
   input  wire                       i_cnt_en,
   input  wire                       i_last,
   output logic                      o_cmp,
   output logic [`SC_XLEN-1:0]       o_rd_data
);

   logic [`SC_XLEN-1:0] rs1_sr;
   logic [`SC_XLEN-1:0] rs2_sr;
   logic [`SC_XLEN-1:0] result;
   logic                carry;
   logic                borrow;
   logic                eq_r;
   logic                lt_r;
   logic                first;

   logic op_a;
   logic op_b;
   logic op_b_add;
   logic carry_in;
   logic sum;
   logic carry_next;
   logic borrow_next;
   logic lt_next;
   logic bool_bit;
   logic rd_bit;
   logic cmp_en;

   assign op_a = rs1_sr[0];
   assign op_b = i_ctrl.op_b_imm ? i_ctrl.imm : rs2_sr[0];

   // Two's complement subtract with a carry-in of one on bit 0
   assign op_b_add   = op_b ^ i_ctrl.alu_sub;
   assign carry_in   = carry | (first & i_ctrl.alu_sub);
   assign sum        = op_a ^ op_b_add ^ carry_in;
   assign carry_next = (op_a & op_b_add) | (carry_in & (op_a ^ op_b_add));

   // Separate rs1 - B borrow chain for the compares
   assign borrow_next = (~op_a & op_b) | (~(op_a ^ op_b) & borrow);
   // On the MSB a negative rs1 is less when the signs differ
   assign lt_next = (~i_ctrl.alu_cmp_uns & (op_a ^ op_b)) ? op_a : borrow_next;

   // xor, or, and from funct3[1:0]
   assign bool_bit = ((op_a ^ op_b) & ~i_ctrl.alu_bool_op[0]) |
                     (i_ctrl.alu_bool_op[1] & op_a & op_b);

   assign rd_bit = (i_ctrl.alu_rd_sel == `SC_ALU_RESULT_BOOL) ? bool_bit : sum;
   assign cmp_en = i_ctrl.branch_op | (i_ctrl.alu_rd_sel == `SC_ALU_RESULT_LT);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry  <= 1'b0;
         borrow <= 1'b0;
         eq_r   <= 1'b0;
         lt_r   <= 1'b0;
         first  <= 1'b0;
      end else if (i_load) begin
         carry  <= 1'b0;
         borrow <= 1'b0;
         eq_r   <= 1'b1;
         lt_r   <= 1'b0;
         first  <= 1'b1;
      end else if (i_cnt_en) begin
         first <= 1'b0;
         carry <= carry_next;
         if (cmp_en) begin
            borrow <= borrow_next;
            eq_r   <= eq_r & ~(op_a ^ op_b);
            lt_r   <= lt_next;
         end
      end
   end

   // Operand and result shifting LSB first
   always_ff @(posedge clk) begin
      if (i_load) begin
         rs1_sr <= i_rs1;
         rs2_sr <= i_rs2;
      end else if (i_cnt_en) begin
         rs1_sr <= {1'b0, rs1_sr[`SC_XLEN-1:1]};
         rs2_sr <= {1'b0, rs2_sr[`SC_XLEN-1:1]};
         if (i_ctrl.rd_alu_en) begin
            if (i_last && (i_ctrl.alu_rd_sel == `SC_ALU_RESULT_LT)) begin
               result <= {{(`SC_XLEN-1){1'b0}}, lt_next};
            end else begin
               result <= {rd_bit, result[`SC_XLEN-1:1]};
            end
         end
      end
   end

   assign o_cmp     = i_ctrl.alu_cmp_eq ? eq_r : lt_r;
   assign o_rd_data = result;

endmodule

`default_nettype wire

// ==== hw/serial_core_defines.svh ====
`ifndef SERIAL_CORE_DEFINES_SVH
`define SERIAL_CORE_DEFINES_SVH

// Word length of the RV32I datapath
`define SC_XLEN 32

// ALU result select codes
`define SC_ALU_RESULT_ADD  2'd0
`define SC_ALU_RESULT_LT   2'd2
`define SC_ALU_RESULT_BOOL 2'd3

// Major opcodes, instruction bits 6 to 2
`define SC_OPC_OPIMM  5'b00100
`define SC_OPC_OP     5'b01100
`define SC_OPC_BRANCH 5'b11000

`endif

// ==== hw/serial_core_pkg.sv ====
`default_nettype none

package serial_core_pkg;

`include "serial_core_defines.svh"

   // Register-register layout
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rtype_t;

   // Store/branch layout with the immediate split around the source registers
   typedef struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
   } stype_t;

   // One instruction word, two views
   typedef union packed {
      rtype_t rtype;
      stype_t stype;
   } instr_u;

   // Decoder to ALU controls
   typedef struct packed {
      logic       alu_sub;
      logic [1:0] alu_bool_op;
      logic       alu_cmp_eq;
      logic       alu_cmp_uns;
      logic [1:0] alu_rd_sel;
      logic       op_b_imm;
      logic       rd_alu_en;
      logic       branch_op;
      // Current immediate bit presented LSB first
      logic       imm;
   } dec_ctrl_t;

   // Completed instruction as seen at the top
   typedef struct packed {
      logic [4:0]          rd_addr;
      logic                rd_we;
      logic [`SC_XLEN-1:0] rd_data;
      logic                take_branch;
   } exec_result_t;

endpackage

`default_nettype wire

// ==== hw/serial_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "serial_core_defines.svh"

module serial_decode
   import serial_core_pkg::*;
(
   input  wire       clk,
   input  wire       i_rst_n,
   // Instruction capture
   input  wire       i_wb_en,
   input  wire instr_u i_wb_rdt,
   // From state and ALU
   input  wire       i_cnt_en,
   input  wire       i_alu_cmp,
   // To ALU
   output dec_ctrl_t o_ctrl,
   // To top
   output logic [4:0] o_rd_addr,
   output logic       o_rd_we,
   output logic       o_take_branch
);

   logic [4:0]          opcode;
   logic [2:0]          funct3;
   logic                imm30;
   logic [4:0]          rd_addr;
   logic [1:0]          alu_rd_sel;
   logic [`SC_XLEN-1:0] imm_sr;

   logic [1:0]          next_rd_sel;
   logic [`SC_XLEN-1:0] next_imm;
   logic                is_op;
   logic                is_opimm;
   logic                is_branch;
   logic                wb_btype;
   logic                sign_bit;

   // Decode of the registered opcode
   assign is_op     = (opcode == `SC_OPC_OP);
   assign is_opimm  = (opcode == `SC_OPC_OPIMM);
   assign is_branch = (opcode == `SC_OPC_BRANCH);

   // Fields of the incoming word
   assign sign_bit = i_wb_rdt.rtype.funct7[6];
   assign wb_btype = (i_wb_rdt.rtype.opcode[6:2] == `SC_OPC_BRANCH);

   // B-type immediate from the split store view and I-type otherwise
   always_comb begin
      if (wb_btype) begin
         next_imm = {{19{sign_bit}},
                     sign_bit,
                     i_wb_rdt.stype.imm_lo[0],
                     i_wb_rdt.stype.imm_hi[5:0],
                     i_wb_rdt.stype.imm_lo[4:1],
                     1'b0};
      end else begin
         next_imm = {{21{sign_bit}},
                     i_wb_rdt.rtype.funct7[5:0],
                     i_wb_rdt.rtype.rs2};
      end
   end

   // Result select is taken straight from the incoming funct3 so that
   // it is already valid for bit 0
   always_comb begin
      casez (i_wb_rdt.rtype.funct3)
         3'b000:  next_rd_sel = `SC_ALU_RESULT_ADD;
         3'b01?:  next_rd_sel = `SC_ALU_RESULT_LT;
         3'b1??:  next_rd_sel = `SC_ALU_RESULT_BOOL;
         default: next_rd_sel = `SC_ALU_RESULT_ADD;
      endcase
   end

   // Major opcode of the captured word
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         opcode <= 5'd0;
      end else if (i_wb_en) begin
         opcode <= i_wb_rdt.rtype.opcode[6:2];
      end
   end

   always_ff @(posedge clk) begin
      if (i_wb_en) begin
         funct3     <= i_wb_rdt.rtype.funct3;
         imm30      <= i_wb_rdt.rtype.funct7[5];
         rd_addr    <= i_wb_rdt.rtype.rd;
         alu_rd_sel <= next_rd_sel;
         imm_sr     <= next_imm;
      end else if (i_cnt_en) begin
         // Rotate right so the LSB comes out first
         imm_sr <= {imm_sr[0], imm_sr[`SC_XLEN-1:1]};
      end
   end

   always_comb begin
      // Only OP uses bit 30 as subtract
      o_ctrl.alu_sub     = is_op & imm30;
      o_ctrl.alu_bool_op = funct3[1:0];
      // beq/bne compare for equality
      o_ctrl.alu_cmp_eq  = (funct3[2:1] == 2'b00);
      // sltu, sltiu, bltu, bgeu
      o_ctrl.alu_cmp_uns = (funct3[0] & funct3[1]) | (funct3[1] & funct3[2]);
      o_ctrl.alu_rd_sel  = alu_rd_sel;
      o_ctrl.op_b_imm    = is_opimm;
      o_ctrl.rd_alu_en   = is_op | is_opimm;
      o_ctrl.branch_op   = is_branch;
      o_ctrl.imm         = imm_sr[0];
   end

   assign o_rd_addr = rd_addr;
   assign o_rd_we   = is_op | is_opimm;

   // bne, bge, bgeu take the branch on a false compare
   assign o_take_branch = is_branch & (i_alu_cmp ^ funct3[0]);

endmodule

`default_nettype wire

// ==== hw/serial_exec_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "serial_core_defines.svh"

module serial_exec_top
   import serial_core_pkg::*;
(
   input  wire                 clk,
   input  wire                 i_rst_n,
   input  wire                 i_wb_en,
   input  wire instr_u         i_wb_rdt,
   input  wire  [`SC_XLEN-1:0] i_rs1,
   input  wire  [`SC_XLEN-1:0] i_rs2,
   output logic                o_busy,
   output logic                o_done,
   output exec_result_t        o_result
);

   logic                start;
   logic                cnt_en;
   logic                last;
   dec_ctrl_t           ctrl;
   logic                alu_cmp;
   logic [`SC_XLEN-1:0] alu_rd_data;
   logic [4:0]          rd_addr;
   logic                rd_we;
   logic                take_branch;

   // Strobes during a running instruction are dropped
   assign start = i_wb_en & ~o_busy;

   serial_state u_state (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_start  (start),
      .o_cnt_en (cnt_en),
      .o_last   (last),
      .o_done   (o_done),
      .o_busy   (o_busy)
   );

   serial_decode u_decode (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_wb_en       (start),
      .i_wb_rdt      (i_wb_rdt),
      .i_cnt_en      (cnt_en),
      .i_alu_cmp     (alu_cmp),
      .o_ctrl        (ctrl),
      .o_rd_addr     (rd_addr),
      .o_rd_we       (rd_we),
      .o_take_branch (take_branch)
   );

   serial_alu u_alu (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_load    (start),
      .i_rs1     (i_rs1),
      .i_rs2     (i_rs2),
      .i_ctrl    (ctrl),
      .i_cnt_en  (cnt_en),
      .i_last    (last),
      .o_cmp     (alu_cmp),
      .o_rd_data (alu_rd_data)
   );

   // Valid in the done cycle only
   assign o_result.rd_addr     = rd_addr;
   assign o_result.rd_we       = rd_we;
   assign o_result.rd_data     = alu_rd_data;
   assign o_result.take_branch = take_branch;

endmodule

`default_nettype wire

// ==== hw/serial_state.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "serial_core_defines.svh"

module serial_state (
   input  wire  clk,
   input  wire  i_rst_n,
   input  wire  i_start,
   output logic o_cnt_en,
   output logic o_last,
   output logic o_done,
   output logic o_busy
);

   localparam logic [4:0] LAST_CNT = 5'(`SC_XLEN - 1);

   logic       busy;
   logic       done_r;
   logic [4:0] cnt;

   // Counting runs while busy until the done cycle
   assign o_cnt_en = busy & ~done_r;
   assign o_last   = o_cnt_en & (cnt == LAST_CNT);
   assign o_done   = done_r;
   assign o_busy   = busy;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         busy   <= 1'b0;
         done_r <= 1'b0;
         cnt    <= 5'd0;
      end else begin
         done_r <= o_last;

         // Busy spans the count phase and the done cycle
         if (i_start) begin
            busy <= 1'b1;
         end else if (done_r) begin
            busy <= 1'b0;
         end

         // Wraps back to zero after the last bit
         if (i_start) begin
            cnt <= 5'd0;
         end else if (o_cnt_en) begin
            cnt <= cnt + 5'd1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
   output logic o_clk,
   output logic o_rst_n
);

   localparam int HALF_PERIOD  = 5;
   localparam int RESET_CYCLES = 2;

   initial begin
      o_clk = 1'b0;
      forever begin
         #HALF_PERIOD o_clk = ~o_clk;
      end
   end

   // Release on a falling edge
   initial begin
      o_rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge o_clk);
      @(negedge o_clk);
      o_rst_n = 1'b1;
   end

endmodule

`default_nettype wire

// ==== sim/tb_serial_exec.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_serial_exec
   import serial_core_pkg::*;
();

   localparam int NUM_ARITH      = 200;
   localparam int NUM_SLT        = 50;
   localparam int NUM_BRANCH     = 100;
   localparam int NUM_BUSY       = 50;
   localparam int NUM_TESTS      = NUM_ARITH + NUM_SLT + NUM_BRANCH + NUM_BUSY;
   localparam int LATENCY        = 33;
   localparam int TIMEOUT_CYCLES = (LATENCY + 1) * NUM_TESTS + 100;

   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;

   // Operand pairs around the sign boundary
   localparam logic [31:0] EDGE_A [4] = '{32'h8000_0000, 32'h7fff_ffff,
                                          32'hffff_ffff, 32'h7fff_ffff};
   localparam logic [31:0] EDGE_B [4] = '{32'h7fff_ffff, 32'h8000_0000,
                                          32'h0000_0001, 32'h7fff_ffff};

   logic         clk;
   logic         rst_n;
   logic         wb_en;
   instr_u       wb_rdt;
   logic [31:0]  rs1;
   logic [31:0]  rs2;
   logic         busy;
   logic         done;
   exec_result_t result;
   integer       seed;
   int           cycle_count = 0;
   logic [31:0]  cur_word;

   tb_clock_gen u_clk_gen (
      .o_clk   (clk),
      .o_rst_n (rst_n)
   );

   serial_exec_top uut (
      .clk      (clk),
      .i_rst_n  (rst_n),
      .i_wb_en  (wb_en),
      .i_wb_rdt (wb_rdt),
      .i_rs1    (rs1),
      .i_rs2    (rs2),
      .o_busy   (busy),
      .o_done   (done),
      .o_result (result)
   );

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1, "Stopped at cycle %0d", cycle_count);
   endtask

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         stop_on_error("Timeout: the tests did not finish within the cycle limit");
      end
   end

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         stop_on_error($sformatf("FAIL %s expected %h got %h", name, exp, act));
      end
   endtask

   task automatic report_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
      stop_on_error($sformatf("FAIL %s expected %h got %h for instruction %h",
                              name, exp, act, cur_word));
   endtask

   task automatic check_result(input exec_result_t exp, input exec_result_t act);
      if (act.rd_addr !== exp.rd_addr) begin
         report_value("o_result.rd_addr", 32'(exp.rd_addr), 32'(act.rd_addr));
      end
      if (act.rd_we !== exp.rd_we) begin
         report_value("o_result.rd_we", 32'(exp.rd_we), 32'(act.rd_we));
      end
      if (act.take_branch !== exp.take_branch) begin
         report_value("o_result.take_branch", 32'(exp.take_branch), 32'(act.take_branch));
      end
      // Data only matters when written
      if (exp.rd_we && (act.rd_data !== exp.rd_data)) begin
         report_value("o_result.rd_data", exp.rd_data, act.rd_data);
      end
   endtask

   // RV32I reference for the supported subset
   function automatic exec_result_t model_exec(input logic [31:0] w, input logic [31:0] a,
                                               input logic [31:0] rs2_val);
      exec_result_t r;
      logic [31:0]  b;
      r         = '0;
      r.rd_addr = w[11:7];
      b         = (w[6:0] == OPC_OPIMM) ? {{20{w[31]}}, w[31:20]} : rs2_val;
      if ((w[6:0] == OPC_OP) || (w[6:0] == OPC_OPIMM)) begin
         r.rd_we = 1'b1;
         case (w[14:12])
            3'b000:  r.rd_data = ((w[6:0] == OPC_OP) && w[30]) ? a - b : a + b;
            3'b010:  r.rd_data = {31'd0, $signed(a) < $signed(b)};
            3'b011:  r.rd_data = {31'd0, a < b};
            3'b100:  r.rd_data = a ^ b;
            3'b110:  r.rd_data = a | b;
            3'b111:  r.rd_data = a & b;
            default: r.rd_we = 1'b0;
         endcase
      end else if (w[6:0] == OPC_BRANCH) begin
         case (w[14:12])
            3'b000:  r.take_branch = (a == b);
            3'b001:  r.take_branch = (a != b);
            3'b100:  r.take_branch = ($signed(a) < $signed(b));
            3'b101:  r.take_branch = ($signed(a) >= $signed(b));
            3'b110:  r.take_branch = (a < b);
            3'b111:  r.take_branch = (a >= b);
            default: r.take_branch = 1'b0;
         endcase
      end
      return r;
   endfunction

   function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2f,
                                            input logic [4:0] rs1f, input logic [2:0] f3,
                                            input logic [4:0] rd);
      return {f7, rs2f, rs1f, f3, rd, OPC_OP};
   endfunction

   function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1f,
                                            input logic [2:0] f3, input logic [4:0] rd);
      return {imm, rs1f, f3, rd, OPC_OPIMM};
   endfunction

   function automatic logic [31:0] encode_b(input logic [12:0] imm, input logic [4:0] rs2f,
                                            input logic [4:0] rs1f, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2f, rs1f, f3, imm[4:1], imm[11], OPC_BRANCH};
   endfunction

   function automatic logic [31:0] rand32();
      return $random(seed);
   endfunction

   function automatic int rand_below(input int n);
      logic [31:0] r;
      r = $random(seed);
      return int'(r % 32'(n));
   endfunction

   // Zero, sign boundary and all-ones show up often
   function automatic logic [31:0] pick_operand();
      logic [31:0] r;
      r = rand32();
      case (r[2:0])
         3'd0:    r = 32'h0000_0000;
         3'd1:    r = 32'h8000_0000;
         3'd2:    r = 32'h7fff_ffff;
         3'd3:    r = 32'hffff_ffff;
         default: ;
      endcase
      return r;
   endfunction

   function automatic logic [11:0] pick_imm12();
      logic [31:0] r;
      logic [11:0] imm;
      r   = rand32();
      imm = r[31:20];
      case (r[2:0])
         3'd0:    imm = 12'h800;
         3'd1:    imm = 12'h7ff;
         3'd2:    imm = 12'hfff;
         3'd3:    imm = 12'h000;
         default: ;
      endcase
      return imm;
   endfunction

   task automatic pick_pair(output logic [31:0] a, output logic [31:0] b);
      a = pick_operand();
      b = (rand_below(4) == 0) ? a : pick_operand();
   endtask

   // Group 0 arithmetic and logic, 1 set-less-than, 2 branch, 3 any
   function automatic logic [31:0] pick_instr(input int group);
      logic [31:0] r;
      logic [31:0] word;
      logic [2:0]  f3;
      logic [11:0] imm;
      int          kind;
      int          k;
      r    = rand32();
      imm  = pick_imm12();
      kind = (group == 3) ? rand_below(3) : group;
      case (kind)
         0: begin
            k  = rand_below(4);
            // add, xor, or, and
            f3 = (k == 0) ? 3'b000 : (k == 1) ? 3'b100 : 3'(k + 4);
            // Bit 30 set on add turns it into sub
            if (r[0]) begin
               word = encode_r({1'b0, r[1] && (f3 == 3'b000), 5'd0}, r[24:20], r[19:15],
                               f3, r[11:7]);
            end else begin
               word = encode_i(imm, r[19:15], f3, r[11:7]);
            end
         end
         1: begin
            f3   = r[1] ? 3'b011 : 3'b010;
            word = r[0] ? encode_r(7'd0, r[24:20], r[19:15], f3, r[11:7])
                        : encode_i(imm, r[19:15], f3, r[11:7]);
         end
         default: begin
            k    = rand_below(6);
            f3   = 3'((k < 2) ? k : k + 2);
            word = encode_b({r[31:20], 1'b0}, r[24:20], r[19:15], f3);
         end
      endcase
      return word;
   endfunction

   // Starts at a falling edge with the DUT idle and ends at cycle 34
   task automatic run_test(input logic [31:0] word, input logic [31:0] a,
                           input logic [31:0] b, input int pulse_cycle);
      exec_result_t exp;
      int           cyc;
      exp      = model_exec(word, a, b);
      cur_word = word;
      check_flag("o_busy", 1'b0, busy);
      wb_en  = 1'b1;
      wb_rdt = word;
      rs1    = a;
      rs2    = b;
      for (cyc = 1; cyc <= LATENCY; cyc++) begin
         @(negedge clk);
         wb_en = (cyc == pulse_cycle);
         // Inputs change freely once captured
         wb_rdt = (cyc == pulse_cycle) ? pick_instr(3) : rand32();
         rs1    = rand32();
         rs2    = rand32();
         check_flag("o_busy", 1'b1, busy);
         check_flag("o_done", cyc == LATENCY, done);
         if (cyc == LATENCY) begin
            check_result(exp, result);
         end
      end
      @(negedge clk);
      wb_en = 1'b0;
      check_flag("o_done", 1'b0, done);
      check_flag("o_busy", 1'b0, busy);
   endtask

   initial begin
      int          i;
      logic [31:0] word;
      logic [31:0] a;
      logic [31:0] b;
      seed   = 32'he27f_65b5;
      wb_en  = 1'b0;
      wb_rdt = '0;
      rs1    = '0;
      rs2    = '0;
      wait (rst_n === 1'b1);
      @(negedge clk);
      check_flag("o_busy", 1'b0, busy);
      check_flag("o_done", 1'b0, done);

      for (i = 0; i < NUM_ARITH; i++) begin
         word = pick_instr(0);
         pick_pair(a, b);
         run_test(word, a, b, 0);
      end

      // slt and sltu on the boundary pairs, then slti and sltiu
      for (i = 0; i < 8; i++) begin
         word = encode_r(7'd0, 5'd2, 5'd1, i[0] ? 3'b011 : 3'b010, 5'd3);
         run_test(word, EDGE_A[i / 2], EDGE_B[i / 2], 0);
      end
      for (i = 0; i < 4; i++) begin
         a    = i[1] ? 32'h8000_0000 : 32'h7fff_ffff;
         word = encode_i(i[1] ? 12'h7ff : 12'h800, 5'd1, i[0] ? 3'b011 : 3'b010, 5'd4);
         run_test(word, a, 32'd0, 0);
      end
      for (i = 12; i < NUM_SLT; i++) begin
         word = pick_instr(1);
         pick_pair(a, b);
         run_test(word, a, b, 0);
      end

      for (i = 0; i < NUM_BRANCH; i++) begin
         word = pick_instr(2);
         pick_pair(a, b);
         run_test(word, a, b, 0);
      end

      // A second strobe somewhere in cycles 1 to 33 must be dropped
      for (i = 0; i < NUM_BUSY; i++) begin
         word = pick_instr(3);
         pick_pair(a, b);
         run_test(word, a, b, 1 + rand_below(LATENCY));
      end

      repeat (LATENCY + 3) begin
         @(negedge clk);
         check_flag("o_done", 1'b0, done);
         check_flag("o_busy", 1'b0, busy);
      end
      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire
